//--- hw/tcdm_pkg.sv
// ##########################################################
// tcdm package: word and address widths, command opcodes
// and streamer states shared across the subsystem
// ##########################################################

`default_nettype none

package tcdm_pkg;

  // memory word, always written in full
  localparam int unsigned DATA_W = 32;

  // global word address, bytes are never addressed
  localparam int unsigned ADDR_W = 16;

  // command opcode, read matches the wen polarity on the channels
  typedef enum logic {
    OP_WRITE = 1'b0,
    OP_READ  = 1'b1
  } tcdm_op_e;

  typedef enum logic [1:0] {
    IDLE  = 2'd0, // waiting for a command
    RUN   = 2'd1, // issuing lockstep steps
    DRAIN = 2'd2  // last read response still in flight
  } strm_state_e;

endpackage

`default_nettype wire

//--- hw/tcdm_streamer.sv
// ##########################################################
// tcdm streamer: turns a command into lockstep channel
// accesses and returns the read data of every step
// ##########################################################

`timescale 1ns/10ps
`default_nettype none

module tcdm_streamer #(
  parameter int unsigned NB_CHAN = 4,
  parameter int unsigned NB_BANK = 8
) (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,

  // command
  input  logic                                     start_i,
  input  tcdm_pkg::tcdm_op_e                       op_i,
  input  logic [tcdm_pkg::ADDR_W-1:0]              base_i,
  input  logic [tcdm_pkg::ADDR_W-1:0]              nwords_i,

  // write stream in, read stream out
  input  logic [NB_CHAN-1:0][tcdm_pkg::DATA_W-1:0] wdata_i,
  input  logic                                     wvalid_i,
  output logic                                     wready_o,
  output logic [NB_CHAN-1:0][tcdm_pkg::DATA_W-1:0] rdata_o,
  output logic                                     rvalid_o,
  output logic                                     busy_o,
  output logic                                     done_o,

  // channel side towards the reorder block
  output logic [$clog2(NB_BANK)-1:0]               order_o,
  output logic [NB_CHAN-1:0]                       ch_req_o,
  output logic [NB_CHAN-1:0][tcdm_pkg::ADDR_W-1:0] ch_add_o,
  output logic [NB_CHAN-1:0]                       ch_wen_o,
  output logic [NB_CHAN-1:0][tcdm_pkg::DATA_W-1:0] ch_wdata_o,
  input  logic                                     ch_gnt_i,
  input  logic [NB_CHAN-1:0][tcdm_pkg::DATA_W-1:0] ch_rdata_i,
  input  logic                                     ch_rvalid_i
);

  import tcdm_pkg::*;

  localparam int unsigned BANK_AW = $clog2(NB_BANK);

  strm_state_e       state_q;
  strm_state_e       state_d;
  tcdm_op_e          op_q;
  logic [ADDR_W-1:0] addr_q;    // word address of channel 0
  logic [ADDR_W-1:0] left_q;    // steps still to issue
  logic              done_q;
  logic              step_req;  // all channels ask together
  logic              step_ok;   // handshake of the current step
  logic              last_step;

  // writes only go out when a beat is offered
  assign step_req  = (state_q == RUN) && ((op_q == OP_READ) || wvalid_i);
  assign step_ok   = step_req && ch_gnt_i;
  assign last_step = (left_q == ADDR_W'(1));

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (start_i && (nwords_i != '0)) begin
          state_d = RUN;
        end
      end
      RUN: begin
        if (step_ok && last_step) begin
          state_d = (op_q == OP_READ) ? DRAIN : IDLE;
        end
      end
      DRAIN: begin
        if (ch_rvalid_i) begin // fixed latency, so this is the last one
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      op_q    <= OP_WRITE;
      addr_q  <= '0;
      left_q  <= '0;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= 1'b0;
      if ((state_q == IDLE) && start_i) begin
        op_q   <= op_i;
        addr_q <= base_i;
        left_q <= nwords_i;
        done_q <= (nwords_i == '0); // empty command ends right away
      end else if (step_ok) begin
        addr_q <= addr_q + ADDR_W'(NB_CHAN);
        left_q <= left_q - ADDR_W'(1);
        if (last_step && (op_q == OP_WRITE)) begin
          done_q <= 1'b1;
        end
      end
      if ((state_q == DRAIN) && ch_rvalid_i) begin
        done_q <= 1'b1;
      end
    end
  end

  // channel i always sits one word above channel i-1
  for (genvar i = 0; i < NB_CHAN; i++) begin : gen_chan_add
    assign ch_add_o[i] = addr_q + ADDR_W'(i);
  end

  assign order_o    = addr_q[BANK_AW-1:0]; // bank of channel 0
  assign ch_req_o   = {NB_CHAN{step_req}};
  assign ch_wen_o   = {NB_CHAN{op_q == OP_READ}};
  assign ch_wdata_o = wdata_i;
  assign wready_o   = step_ok && (op_q == OP_WRITE);

  // responses are already back in channel order
  assign rdata_o  = ch_rdata_i;
  assign rvalid_o = ch_rvalid_i;

  assign busy_o = (state_q != IDLE);
  assign done_o = done_q;

endmodule

`default_nettype wire

//--- hw/tcdm_reorder.sv
// ##########################################################
// tcdm reorder: rotates lockstep channel requests onto
// interleaved banks and read responses back onto channels
// ##########################################################

`timescale 1ns/10ps
`default_nettype none

module tcdm_reorder #(
  parameter int unsigned NB_CHAN    = 4,
  parameter int unsigned NB_BANK    = 8,
  parameter int unsigned BANK_DEPTH = 64
) (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  logic [$clog2(NB_BANK)-1:0]               order_i,

  // channel side
  input  logic [NB_CHAN-1:0]                       ch_req_i,
  input  logic [NB_CHAN-1:0][tcdm_pkg::ADDR_W-1:0] ch_add_i,
  input  logic [NB_CHAN-1:0]                       ch_wen_i,
  input  logic [NB_CHAN-1:0][tcdm_pkg::DATA_W-1:0] ch_wdata_i,
  output logic                                     ch_gnt_o,
  output logic [NB_CHAN-1:0][tcdm_pkg::DATA_W-1:0] ch_rdata_o,
  output logic                                     ch_rvalid_o,

  // bank side
  output logic [NB_BANK-1:0]                       bk_req_o,
  output logic [NB_BANK-1:0][$clog2(BANK_DEPTH)-1:0] bk_add_o,
  output logic [NB_BANK-1:0]                       bk_wen_o,
  output logic [NB_BANK-1:0][tcdm_pkg::DATA_W-1:0] bk_wdata_o,
  input  logic [NB_BANK-1:0]                       bk_gnt_i,
  input  logic [NB_BANK-1:0][tcdm_pkg::DATA_W-1:0] bk_rdata_i
);

  localparam int unsigned BANK_AW  = $clog2(NB_BANK);
  localparam int unsigned DEPTH_AW = $clog2(BANK_DEPTH);

  logic [NB_CHAN-1:0][NB_BANK-1:0] ma_req;  // one-hot bank per channel
  logic [BANK_AW-1:0]              order_q; // rotation of the last granted step
  logic                            rd_q;    // last granted step was a read

  // one shared grant, every addressed bank has to agree
  assign ch_gnt_o = &(~bk_req_o | bk_gnt_i);

  for (genvar i = 0; i < NB_CHAN; i++) begin : gen_chan
    logic [BANK_AW-1:0] bank_sel;
    logic [BANK_AW-1:0] resp_sel;

    assign bank_sel = order_i + BANK_AW'(i); // wraps modulo NB_BANK
    assign resp_sel = order_q + BANK_AW'(i);

    // channel 0 speaks for all channels
    assign ma_req[i] = ch_req_i[0] ? (NB_BANK'(1) << bank_sel) : '0;

    assign ch_rdata_o[i] = bk_rdata_i[resp_sel];
  end

  // banks see at most one channel, so OR-ing is enough
  always_comb begin
    for (int b = 0; b < NB_BANK; b++) begin
      bk_req_o[b]   = 1'b0;
      bk_add_o[b]   = '0;
      bk_wen_o[b]   = ch_wen_i[0];
      bk_wdata_o[b] = '0;
      for (int j = 0; j < NB_CHAN; j++) begin
        bk_req_o[b]   |= ma_req[j][b];
        // row inside the bank is word address / NB_BANK
        bk_add_o[b]   |= ma_req[j][b] ? ch_add_i[j][BANK_AW +: DEPTH_AW] : '0;
        bk_wdata_o[b] |= ma_req[j][b] ? ch_wdata_i[j] : '0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      order_q <= '0;
      rd_q    <= 1'b0;
    end else begin
      rd_q <= ch_req_i[0] & ch_wen_i[0] & ch_gnt_o;
      if (ch_req_i[0] && ch_gnt_o) begin
        order_q <= order_i; // steers next cycle's responses
      end
    end
  end

  assign ch_rvalid_o = rd_q; // fixed latency of one

endmodule

`default_nettype wire

//--- hw/tcdm_bank_array.sv
// ##########################################################
// tcdm bank array: word-interleaved single-port banks with
// stall-driven grant and one-cycle read latency
// ##########################################################

`timescale 1ns/10ps
`default_nettype none

module tcdm_bank_array #(
  parameter int unsigned NB_BANK    = 8,
  parameter int unsigned BANK_DEPTH = 64
) (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,

  // models other masters holding a bank
  input  logic [NB_BANK-1:0]                         stall_i,

  input  logic [NB_BANK-1:0]                         bk_req_i,
  input  logic [NB_BANK-1:0][$clog2(BANK_DEPTH)-1:0] bk_add_i,
  input  logic [NB_BANK-1:0]                         bk_wen_i,
  input  logic [NB_BANK-1:0][tcdm_pkg::DATA_W-1:0]   bk_wdata_i,
  output logic [NB_BANK-1:0]                         bk_gnt_o,
  output logic [NB_BANK-1:0][tcdm_pkg::DATA_W-1:0]   bk_rdata_o
);

  import tcdm_pkg::*;

  // a free bank takes any request in the same cycle
  assign bk_gnt_o = bk_req_i & ~stall_i;

  for (genvar b = 0; b < NB_BANK; b++) begin : gen_bank
    logic [DATA_W-1:0] mem [BANK_DEPTH];
    logic [DATA_W-1:0] rdata_q;

    // wen low means write
    always_ff @(posedge clk_i) begin
      if (bk_gnt_o[b] && !bk_wen_i[b]) begin
        mem[bk_add_i[b]] <= bk_wdata_i[b];
      end
    end

    // output register holds the last read word
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rdata_q <= '0;
      end else if (bk_gnt_o[b] && bk_wen_i[b]) begin
        rdata_q <= mem[bk_add_i[b]];
      end
    end

    assign bk_rdata_o[b] = rdata_q;
  end

endmodule

`default_nettype wire

//--- hw/tcdm_top.sv
// ##########################################################
// tcdm top: streamer, channel reorder and interleaved banks
// ##########################################################

`timescale 1ns/10ps
`default_nettype none

module tcdm_top #(
  parameter int unsigned NB_CHAN    = 4,
  parameter int unsigned NB_BANK    = 8,  // power of two, at least NB_CHAN
  parameter int unsigned BANK_DEPTH = 64  // words per bank
) (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,

  input  logic                                     start_i,
  input  tcdm_pkg::tcdm_op_e                       op_i,
  input  logic [tcdm_pkg::ADDR_W-1:0]              base_i,
  input  logic [tcdm_pkg::ADDR_W-1:0]              nwords_i, // lockstep steps

  input  logic [NB_CHAN-1:0][tcdm_pkg::DATA_W-1:0] wdata_i,
  input  logic                                     wvalid_i,
  output logic                                     wready_o,
  output logic [NB_CHAN-1:0][tcdm_pkg::DATA_W-1:0] rdata_o,
  output logic                                     rvalid_o,
  output logic                                     busy_o,
  output logic                                     done_o,

  input  logic [NB_BANK-1:0]                       stall_i
);

  import tcdm_pkg::*;

  localparam int unsigned BANK_AW  = $clog2(NB_BANK);
  localparam int unsigned DEPTH_AW = $clog2(BANK_DEPTH);

  // channel side
  logic [BANK_AW-1:0]                order;
  logic [NB_CHAN-1:0]                ch_req;
  logic [NB_CHAN-1:0][ADDR_W-1:0]    ch_add;
  logic [NB_CHAN-1:0]                ch_wen;
  logic [NB_CHAN-1:0][DATA_W-1:0]    ch_wdata;
  logic                              ch_gnt;
  logic [NB_CHAN-1:0][DATA_W-1:0]    ch_rdata;
  logic                              ch_rvalid;

  // bank side
  logic [NB_BANK-1:0]                bk_req;
  logic [NB_BANK-1:0][DEPTH_AW-1:0]  bk_add;
  logic [NB_BANK-1:0]                bk_wen;
  logic [NB_BANK-1:0][DATA_W-1:0]    bk_wdata;
  logic [NB_BANK-1:0]                bk_gnt;
  logic [NB_BANK-1:0][DATA_W-1:0]    bk_rdata;

  tcdm_streamer #(
    .NB_CHAN ( NB_CHAN ),
    .NB_BANK ( NB_BANK )
  ) u_streamer (
    .clk_i       ( clk_i     ),
    .rst_ni      ( rst_ni    ),
    .start_i     ( start_i   ),
    .op_i        ( op_i      ),
    .base_i      ( base_i    ),
    .nwords_i    ( nwords_i  ),
    .wdata_i     ( wdata_i   ),
    .wvalid_i    ( wvalid_i  ),
    .wready_o    ( wready_o  ),
    .rdata_o     ( rdata_o   ),
    .rvalid_o    ( rvalid_o  ),
    .busy_o      ( busy_o    ),
    .done_o      ( done_o    ),
    .order_o     ( order     ),
    .ch_req_o    ( ch_req    ),
    .ch_add_o    ( ch_add    ),
    .ch_wen_o    ( ch_wen    ),
    .ch_wdata_o  ( ch_wdata  ),
    .ch_gnt_i    ( ch_gnt    ),
    .ch_rdata_i  ( ch_rdata  ),
    .ch_rvalid_i ( ch_rvalid )
  );

  tcdm_reorder #(
    .NB_CHAN    ( NB_CHAN    ),
    .NB_BANK    ( NB_BANK    ),
    .BANK_DEPTH ( BANK_DEPTH )
  ) u_reorder (
    .clk_i       ( clk_i     ),
    .rst_ni      ( rst_ni    ),
    .order_i     ( order     ),
    .ch_req_i    ( ch_req    ),
    .ch_add_i    ( ch_add    ),
    .ch_wen_i    ( ch_wen    ),
    .ch_wdata_i  ( ch_wdata  ),
    .ch_gnt_o    ( ch_gnt    ),
    .ch_rdata_o  ( ch_rdata  ),
    .ch_rvalid_o ( ch_rvalid ),
    .bk_req_o    ( bk_req    ),
    .bk_add_o    ( bk_add    ),
    .bk_wen_o    ( bk_wen    ),
    .bk_wdata_o  ( bk_wdata  ),
    .bk_gnt_i    ( bk_gnt    ),
    .bk_rdata_i  ( bk_rdata  )
  );

  tcdm_bank_array #(
    .NB_BANK    ( NB_BANK    ),
    .BANK_DEPTH ( BANK_DEPTH )
  ) u_banks (
    .clk_i      ( clk_i    ),
    .rst_ni     ( rst_ni   ),
    .stall_i    ( stall_i  ),
    .bk_req_i   ( bk_req   ),
    .bk_add_i   ( bk_add   ),
    .bk_wen_i   ( bk_wen   ),
    .bk_wdata_i ( bk_wdata ),
    .bk_gnt_o   ( bk_gnt   ),
    .bk_rdata_o ( bk_rdata )
  );

endmodule

`default_nettype wire

//--- sim/tcdm_top_sva.sv
// ##########################################################
// tcdm reorder checks: bank mapping, read response timing
// and request stability under back-pressure
// ##########################################################

`timescale 1ns/10ps
`default_nettype none

module tcdm_top_sva #(
  parameter int unsigned NB_CHAN    = 4,
  parameter int unsigned NB_BANK    = 8,
  parameter int unsigned BANK_DEPTH = 64
) (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  input  logic [NB_CHAN-1:0]                         ch_req_i,
  input  logic [NB_CHAN-1:0][tcdm_pkg::ADDR_W-1:0]   ch_add_i,
  input  logic [NB_CHAN-1:0]                         ch_wen_i,
  input  logic [NB_CHAN-1:0][tcdm_pkg::DATA_W-1:0]   ch_wdata_i,
  input  logic                                       ch_gnt_i,
  input  logic                                       ch_rvalid_i,
  input  logic [NB_BANK-1:0]                         bk_req_i,
  input  logic [NB_BANK-1:0][$clog2(BANK_DEPTH)-1:0] bk_add_i
);

  localparam int unsigned BANK_AW  = $clog2(NB_BANK);
  localparam int unsigned DEPTH_AW = $clog2(BANK_DEPTH);

  int unsigned err_cnt = 0; // failed assertions so far

  logic rd_step; // granted read step
  logic wr_step; // granted write step

  assign rd_step = ch_req_i[0] && ch_gnt_i && ch_wen_i[0];
  assign wr_step = ch_req_i[0] && ch_gnt_i && !ch_wen_i[0];

  // each channel lands on the bank its own word address selects
  for (genvar i = 0; i < NB_CHAN; i++) begin : gen_map
    logic [BANK_AW-1:0] home; // bank that owns the channel's word

    assign home = ch_add_i[i][BANK_AW-1:0];

    a_home_bank: assert property (@(posedge clk_i) disable iff (!rst_ni)
      ch_req_i[0] |-> (bk_req_i[home]
                       && (bk_add_i[home] == ch_add_i[i][BANK_AW +: DEPTH_AW])))
      else begin
        err_cnt++;
        $error("channel %0d does not reach the bank of its address", i);
      end
  end

  // with every channel on its home bank, extra requests mean a shared or stray bank
  a_distinct: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ch_req_i[0] |-> ($countones(bk_req_i) == NB_CHAN))
    else begin
      err_cnt++;
      $error("two channels address the same bank");
    end

  a_rd_resp: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_step |=> ch_rvalid_i)
    else begin
      err_cnt++;
      $error("no read response one cycle after a granted read step");
    end

  a_wr_quiet: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wr_step |=> !ch_rvalid_i)
    else begin
      err_cnt++;
      $error("read response after a granted write step");
    end

  a_no_spurious: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ch_rvalid_i |-> $past(rd_step))
    else begin
      err_cnt++;
      $error("read response without a granted read step before it");
    end

  // all channels wait together while any target bank stalls
  a_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (ch_req_i[0] && !ch_gnt_i) |=> (ch_req_i[0] && $stable(ch_add_i)
                                    && $stable(ch_wen_i) && $stable(ch_wdata_i)))
    else begin
      err_cnt++;
      $error("request changed or dropped while waiting for grant");
    end

endmodule

bind tcdm_reorder tcdm_top_sva #(
  .NB_CHAN    ( NB_CHAN    ),
  .NB_BANK    ( NB_BANK    ),
  .BANK_DEPTH ( BANK_DEPTH )
) u_sva (
  .clk_i       ( clk_i       ),
  .rst_ni      ( rst_ni      ),
  .ch_req_i    ( ch_req_i    ),
  .ch_add_i    ( ch_add_i    ),
  .ch_wen_i    ( ch_wen_i    ),
  .ch_wdata_i  ( ch_wdata_i  ),
  .ch_gnt_i    ( ch_gnt_o    ),
  .ch_rvalid_i ( ch_rvalid_o ),
  .bk_req_i    ( bk_req_o    ),
  .bk_add_i    ( bk_add_o    )
);

`default_nettype wire

//--- sim/tb_tcdm_top.sv
// ##########################################################
// tcdm top testbench: write and read streams at rotated
// bases and under random bank stalls, with a reference memory
// ##########################################################

`timescale 1ns/10ps
`default_nettype none

module tb_tcdm_top;

  import tcdm_pkg::*;

  localparam int unsigned NB_CHAN    = 4;
  localparam int unsigned NB_BANK    = 8;
  localparam int unsigned BANK_DEPTH = 64;
  localparam int unsigned MEM_WORDS  = NB_BANK * BANK_DEPTH;
  localparam int unsigned MAX_STEPS  = 8;
  localparam int unsigned TIMEOUT    = 400; // cycles per command

  logic                           clk_i;
  logic                           rst_ni;
  logic                           start_i;
  tcdm_op_e                       op_i;
  logic [ADDR_W-1:0]              base_i;
  logic [ADDR_W-1:0]              nwords_i;
  logic [NB_CHAN-1:0][DATA_W-1:0] wdata_i;
  logic                           wvalid_i;
  logic                           wready_o;
  logic [NB_CHAN-1:0][DATA_W-1:0] rdata_o;
  logic                           rvalid_o;
  logic                           busy_o;
  logic                           done_o;
  logic [NB_BANK-1:0]             stall_i;

  logic [DATA_W-1:0] ref_mem [MEM_WORDS]; // indexed by global word address
  logic [31:0]       rng_state = 32'hce2a09d9;
  string             test_name;
  int unsigned       cur_base;
  int unsigned       wr_beats;
  int unsigned       rd_beats;
  int unsigned       done_cnt;
  int unsigned       mismatch_cnt;
  int unsigned       fail_cnt;
  bit                timed_out;

  initial clk_i = 1'b0;
  always #20 clk_i = ~clk_i;

  tcdm_top #(
    .NB_CHAN    ( NB_CHAN    ),
    .NB_BANK    ( NB_BANK    ),
    .BANK_DEPTH ( BANK_DEPTH )
  ) u_dut (
    .clk_i    ( clk_i    ),
    .rst_ni   ( rst_ni   ),
    .start_i  ( start_i  ),
    .op_i     ( op_i     ),
    .base_i   ( base_i   ),
    .nwords_i ( nwords_i ),
    .wdata_i  ( wdata_i  ),
    .wvalid_i ( wvalid_i ),
    .wready_o ( wready_o ),
    .rdata_o  ( rdata_o  ),
    .rvalid_o ( rvalid_o ),
    .busy_o   ( busy_o   ),
    .done_o   ( done_o   ),
    .stall_i  ( stall_i  )
  );

  function automatic logic [31:0] rand32();
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
  endfunction

  task automatic drive_beat();
    for (int i = 0; i < NB_CHAN; i++) begin
      wdata_i[i] = rand32();
    end
  endtask

  task automatic check_count(input string what, input int unsigned exp_val,
                             input int unsigned act_val);
    assert (act_val == exp_val) else begin
      $display("MISMATCH test=%s %s expected=%0d actual=%0d", test_name, what,
               exp_val, act_val);
      mismatch_cnt++;
    end
  endtask

  // sampled on the rising edge, inputs settled half a cycle earlier
  always @(posedge clk_i) begin
    logic [DATA_W-1:0] exp_word;
    if (rst_ni) begin
      if (wready_o) begin
        for (int i = 0; i < NB_CHAN; i++) begin
          ref_mem[cur_base + wr_beats * NB_CHAN + i] = wdata_i[i];
        end
        wr_beats++;
      end
      if (rvalid_o) begin
        for (int i = 0; i < NB_CHAN; i++) begin
          exp_word = ref_mem[cur_base + rd_beats * NB_CHAN + i];
          assert (rdata_o[i] === exp_word) else begin
            $display("MISMATCH test=%s step=%0d ch=%0d expected=%08h actual=%08h",
                     test_name, rd_beats, i, exp_word, rdata_o[i]);
            mismatch_cnt++;
          end
        end
        rd_beats++;
      end
      if (done_o) begin
        done_cnt++;
      end
    end
  end

  task automatic run_cmd(input string name, input tcdm_op_e op, input int unsigned base,
                         input int unsigned steps, input bit stalls);
    int unsigned cycles;
    int unsigned beats_seen;
    if (!timed_out) begin
      @(negedge clk_i);
      test_name  = name;
      cur_base   = base;
      wr_beats   = 0;
      rd_beats   = 0;
      done_cnt   = 0;
      beats_seen = 0;
      cycles     = 0;
      start_i    = 1'b1;
      op_i       = op;
      base_i     = ADDR_W'(base);
      nwords_i   = ADDR_W'(steps);
      wvalid_i   = (op == OP_WRITE);
      if (op == OP_WRITE) begin
        drive_beat();
      end
      @(negedge clk_i);
      start_i = 1'b0;
      while ((done_cnt == 0) && (cycles < TIMEOUT)) begin
        stall_i = stalls ? NB_BANK'(rand32() & rand32()) : '0; // about one bank in four
        if (wr_beats != beats_seen) begin // beat taken, offer the next one
          beats_seen = wr_beats;
          wvalid_i   = (wr_beats < steps);
          drive_beat();
        end
        @(negedge clk_i);
        cycles++;
      end
      stall_i  = '0;
      wvalid_i = 1'b0;
      if (done_cnt == 0) begin
        $display("timeout: no done_o within %0d cycles in test %s", TIMEOUT, name);
        fail_cnt++;
        timed_out = 1'b1;
      end else begin
        repeat (2) @(negedge clk_i); // window for a second done_o
        check_count("done_o pulses", 1, done_cnt);
        check_count("busy_o after done", 0, busy_o);
        check_count("wready_o pulses", (op == OP_WRITE) ? steps : 0, wr_beats);
        check_count("rvalid_o pulses", (op == OP_READ) ? steps : 0, rd_beats);
      end
    end
  endtask

  initial begin
    int unsigned base;
    int unsigned steps;
    rst_ni       = 1'b0;
    start_i      = 1'b0;
    op_i         = OP_WRITE;
    base_i       = '0;
    nwords_i     = '0;
    wdata_i      = '0;
    wvalid_i     = 1'b0;
    stall_i      = '0;
    test_name    = "reset";
    cur_base     = 0;
    wr_beats     = 0;
    rd_beats     = 0;
    done_cnt     = 0;
    mismatch_cnt = 0;
    fail_cnt     = 0;
    timed_out    = 1'b0;
    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_count("busy_o", 0, busy_o);
    check_count("done_o", 0, done_o);
    check_count("rvalid_o", 0, rvalid_o);
    check_count("wready_o", 0, wready_o);

    // every bank offset once clean, then once with stalls
    for (int k = 0; k < 2 * NB_BANK; k++) begin
      base  = (rand32() % ((MEM_WORDS - MAX_STEPS * NB_CHAN) / NB_BANK)) * NB_BANK
              + (k % NB_BANK);
      steps = 1 + (rand32() % MAX_STEPS);
      run_cmd((k < NB_BANK) ? "rot_write" : "stall_write", OP_WRITE, base, steps,
              k >= NB_BANK);
      run_cmd((k < NB_BANK) ? "rot_read" : "stall_read", OP_READ, base, steps,
              k >= NB_BANK);
    end

    $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
             mismatch_cnt, fail_cnt, u_dut.u_reorder.u_sva.err_cnt);
    if ((mismatch_cnt + fail_cnt + u_dut.u_reorder.u_sva.err_cnt) == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
hw/tcdm_pkg.sv
hw/tcdm_streamer.sv
hw/tcdm_reorder.sv
hw/tcdm_bank_array.sv
hw/tcdm_top.sv
sim/tcdm_top_sva.sv
sim/tb_tcdm_top.sv
